/* src/cpu_isa_pkg.sv */
package cpu_isa_pkg;

	// Word and register file geometry
	localparam int WORD_W = 16;
	localparam int REG_ADDR_W = 4;
	localparam int NUM_REGS = 1 << REG_ADDR_W;

	// Immediate field widths
	localparam int IMM4_W = 4;
	localparam int IMM8_W = 8;
	localparam int IMM9_W = 9;
	localparam int IMM12_W = 12;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// JAL writes its return address here
	localparam reg_addr_t LINK_REG = 4'd15;

	// Opcode in bits 15..12, codes 6 and 7 unused
	typedef enum logic [3:0] {
		OP_ADD = 4'h0, OP_SUB = 4'h1, OP_AND = 4'h2, OP_NOR = 4'h3,
		OP_SLL = 4'h4, OP_SRL = 4'h5, OP_LW = 4'h8, OP_SW = 4'h9,
		OP_LLB = 4'hA, OP_LHB = 4'hB, OP_B = 4'hC, OP_JAL = 4'hD,
		OP_JR = 4'hE, OP_HLT = 4'hF
	} opcode_t;

	// Branch condition, bits 11..9 of B
	typedef enum logic [2:0] {
		COND_NE, COND_EQ, COND_GT, COND_LT, COND_GE, COND_LE, COND_OV, COND_ALWAYS
	} cond_t;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_NOR, ALU_SLL, ALU_SRL, ALU_PASS_B, ALU_MERGE_HI
	} alu_op_t;

	// Second read port in use (rt, or rd for SW and LHB)
	function automatic logic reads_rt(input opcode_t op);
		return op inside {OP_ADD, OP_SUB, OP_AND, OP_NOR, OP_SW, OP_LHB};
	endfunction

endpackage

/* src/cpu_pipe_pkg.sv */
package cpu_pipe_pkg;

	// Decoded control bundle
	typedef struct packed {
		cpu_isa_pkg::alu_op_t alu_op;
		logic src_imm;
		logic reg_we;
		logic mem_we;
		logic mem_re;
		logic mem_to_reg;
		logic sets_flags;
		logic is_branch;
		logic is_jal;
		logic is_jr;
		logic is_halt;
	} ctrl_t;

	// Pipeline payloads, all-zero is a bubble
	typedef struct packed {
		logic valid;
		cpu_isa_pkg::word_t pc_next;
		cpu_isa_pkg::word_t instr;
	} if_id_t;

	typedef struct packed {
		logic valid;
		ctrl_t ctrl;
		cpu_isa_pkg::cond_t cond;
		cpu_isa_pkg::word_t opa;
		cpu_isa_pkg::word_t opb;
		cpu_isa_pkg::reg_addr_t rs;
		// Second read address, rt or rd
		cpu_isa_pkg::reg_addr_t rt;
		cpu_isa_pkg::reg_addr_t rd;
		cpu_isa_pkg::word_t imm;
		cpu_isa_pkg::word_t pc_next;
	} id_ex_t;

	typedef struct packed {
		logic valid;
		cpu_isa_pkg::word_t result;
		cpu_isa_pkg::word_t store_data;
		cpu_isa_pkg::reg_addr_t rd;
		logic reg_we;
		logic mem_we;
		logic mem_re;
		logic mem_to_reg;
		logic is_halt;
	} ex_mem_t;

	typedef struct packed {
		logic valid;
		cpu_isa_pkg::word_t result;
		cpu_isa_pkg::word_t load_data;
		cpu_isa_pkg::reg_addr_t rd;
		logic reg_we;
		logic mem_to_reg;
		logic is_halt;
	} mem_wb_t;

	// Operand source in EX
	typedef enum logic [1:0] {
		FWD_NONE,
		FWD_EXMEM,
		FWD_MEMWB
	} fwd_sel_t;

endpackage

/* src/pipe_reg.sv */
`timescale 1ns/1ps

// Generic stage register
module pipe_reg #(
	parameter type PAYLOAD_T = logic [15:0]
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     stall,
	input  logic     flush,
	input  PAYLOAD_T d,
	output PAYLOAD_T q
);

	// Zero payload means valid low
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			q <= PAYLOAD_T'('0);
		end else if (!stall) begin
			q <= d;
		end
		// else hold for the stall
	end

endmodule

/* src/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode (
	input  logic                   clk,
	input  logic                   rst,
	input  cpu_pipe_pkg::if_id_t   if_id,
	input  logic                   wb_we,
	input  cpu_isa_pkg::reg_addr_t wb_rd,
	input  cpu_isa_pkg::word_t     wb_data,
	output cpu_pipe_pkg::id_ex_t   id_ex
);

	cpu_isa_pkg::word_t regs [0:cpu_isa_pkg::NUM_REGS-1];
	cpu_isa_pkg::opcode_t op;
	cpu_isa_pkg::reg_addr_t rs_addr;
	cpu_isa_pkg::reg_addr_t rt_addr;
	cpu_isa_pkg::reg_addr_t rd_addr;
	cpu_isa_pkg::word_t rs_val;
	cpu_isa_pkg::word_t rt_val;
	cpu_isa_pkg::word_t imm;
	cpu_pipe_pkg::ctrl_t ctrl;
	logic reads_rs;

	assign op = cpu_isa_pkg::opcode_t'(if_id.instr[15:12]);

	// Register file, r0 never written
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < cpu_isa_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_we && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// Read addresses
	assign reads_rs = !(op inside {cpu_isa_pkg::OP_LLB, cpu_isa_pkg::OP_LHB,
		cpu_isa_pkg::OP_B, cpu_isa_pkg::OP_JAL, cpu_isa_pkg::OP_HLT});
	assign rs_addr = (if_id.valid && reads_rs) ? if_id.instr[7:4] : '0;
	// SW data and LHB low byte come from rd
	assign rt_addr = (op inside {cpu_isa_pkg::OP_SW, cpu_isa_pkg::OP_LHB}) ?
		if_id.instr[11:8] : if_id.instr[3:0];
	assign rd_addr = (op == cpu_isa_pkg::OP_JAL) ? cpu_isa_pkg::LINK_REG : if_id.instr[11:8];

	// Same-cycle write reads through
	assign rs_val = (rs_addr == '0) ? '0 : (wb_we && wb_rd == rs_addr) ? wb_data : regs[rs_addr];
	assign rt_val = (rt_addr == '0) ? '0 : (wb_we && wb_rd == rt_addr) ? wb_data : regs[rt_addr];

	// Control decode
	always_comb begin
		ctrl = '0;
		case (op)
			cpu_isa_pkg::OP_SUB: ctrl.alu_op = cpu_isa_pkg::ALU_SUB;
			cpu_isa_pkg::OP_AND: ctrl.alu_op = cpu_isa_pkg::ALU_AND;
			cpu_isa_pkg::OP_NOR: ctrl.alu_op = cpu_isa_pkg::ALU_NOR;
			cpu_isa_pkg::OP_SLL: ctrl.alu_op = cpu_isa_pkg::ALU_SLL;
			cpu_isa_pkg::OP_SRL: ctrl.alu_op = cpu_isa_pkg::ALU_SRL;
			cpu_isa_pkg::OP_LLB: ctrl.alu_op = cpu_isa_pkg::ALU_PASS_B;
			cpu_isa_pkg::OP_LHB: ctrl.alu_op = cpu_isa_pkg::ALU_MERGE_HI;
			// Address adds land here too
			default: ctrl.alu_op = cpu_isa_pkg::ALU_ADD;
		endcase
		ctrl.src_imm = op inside {cpu_isa_pkg::OP_SLL, cpu_isa_pkg::OP_SRL, cpu_isa_pkg::OP_LW,
			cpu_isa_pkg::OP_SW, cpu_isa_pkg::OP_LLB, cpu_isa_pkg::OP_LHB};
		ctrl.sets_flags = op inside {cpu_isa_pkg::OP_ADD, cpu_isa_pkg::OP_SUB,
			cpu_isa_pkg::OP_AND, cpu_isa_pkg::OP_NOR};
		ctrl.reg_we = ctrl.sets_flags || ctrl.src_imm && op != cpu_isa_pkg::OP_SW ||
			op == cpu_isa_pkg::OP_JAL;
		ctrl.mem_we = op == cpu_isa_pkg::OP_SW;
		ctrl.mem_re = op == cpu_isa_pkg::OP_LW;
		ctrl.mem_to_reg = op == cpu_isa_pkg::OP_LW;
		ctrl.is_branch = op == cpu_isa_pkg::OP_B;
		ctrl.is_jal = op == cpu_isa_pkg::OP_JAL;
		ctrl.is_jr = op == cpu_isa_pkg::OP_JR;
		ctrl.is_halt = op == cpu_isa_pkg::OP_HLT;
		if (!if_id.valid) begin
			ctrl = '0;
		end
	end

	// Immediate extension
	always_comb begin
		case (op)
			cpu_isa_pkg::OP_SLL, cpu_isa_pkg::OP_SRL:
				imm = cpu_isa_pkg::word_t'(if_id.instr[cpu_isa_pkg::IMM4_W-1:0]);
			cpu_isa_pkg::OP_LW, cpu_isa_pkg::OP_SW:
				imm = cpu_isa_pkg::word_t'(signed'(if_id.instr[cpu_isa_pkg::IMM4_W-1:0]));
			cpu_isa_pkg::OP_LLB:
				imm = cpu_isa_pkg::word_t'(signed'(if_id.instr[cpu_isa_pkg::IMM8_W-1:0]));
			cpu_isa_pkg::OP_LHB:
				imm = cpu_isa_pkg::word_t'(if_id.instr[cpu_isa_pkg::IMM8_W-1:0]);
			cpu_isa_pkg::OP_B:
				imm = cpu_isa_pkg::word_t'(signed'(if_id.instr[cpu_isa_pkg::IMM9_W-1:0]));
			cpu_isa_pkg::OP_JAL:
				imm = cpu_isa_pkg::word_t'(signed'(if_id.instr[cpu_isa_pkg::IMM12_W-1:0]));
			default: imm = '0;
		endcase
	end

	// Next ID/EX payload
	always_comb begin
		id_ex.valid = if_id.valid;
		id_ex.ctrl = ctrl;
		id_ex.cond = cpu_isa_pkg::cond_t'(if_id.instr[11:9]);
		id_ex.opa = rs_val;
		id_ex.opb = rt_val;
		id_ex.rs = rs_addr;
		id_ex.rt = if_id.valid ? rt_addr : '0;
		id_ex.rd = rd_addr;
		id_ex.imm = imm;
		id_ex.pc_next = if_id.pc_next;
	end

endmodule

/* src/execute.sv */
`timescale 1ns/1ps

module execute (
	input  logic                   clk,
	input  logic                   rst,
	input  cpu_pipe_pkg::id_ex_t   id_ex,
	input  cpu_pipe_pkg::fwd_sel_t fwd_a,
	input  cpu_pipe_pkg::fwd_sel_t fwd_b,
	input  cpu_isa_pkg::word_t     ex_mem_fwd,
	input  cpu_isa_pkg::word_t     mem_wb_fwd,
	output cpu_pipe_pkg::ex_mem_t  ex_mem,
	output logic                   redirect,
	output cpu_isa_pkg::word_t     redirect_pc
);

	localparam int MSB = cpu_isa_pkg::WORD_W - 1;

	cpu_isa_pkg::word_t opa;
	cpu_isa_pkg::word_t opb;
	cpu_isa_pkg::word_t alu_b;
	cpu_isa_pkg::word_t alu_out;
	logic ovf;
	logic flag_n;
	logic flag_z;
	logic flag_v;
	logic taken;

	function automatic cpu_isa_pkg::word_t fwd_mux(
		input cpu_pipe_pkg::fwd_sel_t sel,
		input cpu_isa_pkg::word_t     reg_val,
		input cpu_isa_pkg::word_t     exm,
		input cpu_isa_pkg::word_t     mwb
	);
		case (sel)
			cpu_pipe_pkg::FWD_EXMEM: return exm;
			cpu_pipe_pkg::FWD_MEMWB: return mwb;
			default: return reg_val;
		endcase
	endfunction

	// Forwarded operands
	assign opa = fwd_mux(fwd_a, id_ex.opa, ex_mem_fwd, mem_wb_fwd);
	assign opb = fwd_mux(fwd_b, id_ex.opb, ex_mem_fwd, mem_wb_fwd);
	assign alu_b = id_ex.ctrl.src_imm ? id_ex.imm : opb;

	////////////////////////////////////////
	// ALU
	always_comb begin
		ovf = 1'b0;
		case (id_ex.ctrl.alu_op)
			cpu_isa_pkg::ALU_ADD: begin
				alu_out = opa + alu_b;
				ovf = (opa[MSB] == alu_b[MSB]) && (alu_out[MSB] != opa[MSB]);
			end
			cpu_isa_pkg::ALU_SUB: begin
				alu_out = opa - alu_b;
				ovf = (opa[MSB] != alu_b[MSB]) && (alu_out[MSB] != opa[MSB]);
			end
			cpu_isa_pkg::ALU_AND: alu_out = opa & alu_b;
			cpu_isa_pkg::ALU_NOR: alu_out = ~(opa | alu_b);
			cpu_isa_pkg::ALU_SLL: alu_out = opa << alu_b[cpu_isa_pkg::IMM4_W-1:0];
			cpu_isa_pkg::ALU_SRL: alu_out = opa >> alu_b[cpu_isa_pkg::IMM4_W-1:0];
			cpu_isa_pkg::ALU_PASS_B: alu_out = alu_b;
			// LHB keeps the low byte of rd
			default: alu_out = {alu_b[cpu_isa_pkg::IMM8_W-1:0], opb[7:0]};
		endcase
	end

	// NZV, V only from add and sub
	always_ff @(posedge clk) begin
		if (rst) begin
			flag_n <= 1'b0;
			flag_z <= 1'b0;
			flag_v <= 1'b0;
		end else if (id_ex.valid && id_ex.ctrl.sets_flags) begin
			flag_n <= alu_out[MSB];
			flag_z <= (alu_out == '0);
			flag_v <= ovf;
		end
	end

	////////////////////////////////////////
	// Branch and jump resolution
	always_comb begin
		case (id_ex.cond)
			cpu_isa_pkg::COND_NE: taken = !flag_z;
			cpu_isa_pkg::COND_EQ: taken = flag_z;
			cpu_isa_pkg::COND_GT: taken = !flag_z && !flag_n;
			cpu_isa_pkg::COND_LT: taken = flag_n;
			cpu_isa_pkg::COND_GE: taken = !flag_n;
			cpu_isa_pkg::COND_LE: taken = flag_n || flag_z;
			cpu_isa_pkg::COND_OV: taken = flag_v;
			default: taken = 1'b1;
		endcase
	end

	assign redirect = id_ex.valid &&
		(id_ex.ctrl.is_jal || id_ex.ctrl.is_jr || (id_ex.ctrl.is_branch && taken));
	// B and JAL are pc+1 relative
	assign redirect_pc = id_ex.ctrl.is_jr ? opa : id_ex.pc_next + id_ex.imm;

	// Next EX/MEM payload
	always_comb begin
		ex_mem.valid = id_ex.valid;
		// JAL links pc+1
		ex_mem.result = id_ex.ctrl.is_jal ? id_ex.pc_next : alu_out;
		ex_mem.store_data = opb;
		ex_mem.rd = id_ex.rd;
		ex_mem.reg_we = id_ex.ctrl.reg_we;
		ex_mem.mem_we = id_ex.ctrl.mem_we;
		ex_mem.mem_re = id_ex.ctrl.mem_re;
		ex_mem.mem_to_reg = id_ex.ctrl.mem_to_reg;
		ex_mem.is_halt = id_ex.ctrl.is_halt;
	end

endmodule

/* src/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
	input  logic                   clk,
	input  logic                   rst,
	input  cpu_isa_pkg::reg_addr_t id_rs,
	input  cpu_isa_pkg::reg_addr_t id_rt,
	input  logic                   id_reads_rt,
	input  cpu_isa_pkg::reg_addr_t ex_rd,
	input  logic                   ex_is_load,
	input  cpu_isa_pkg::reg_addr_t ex_rs,
	input  cpu_isa_pkg::reg_addr_t ex_rt,
	input  cpu_isa_pkg::reg_addr_t mem_rd,
	input  logic                   mem_reg_we,
	input  cpu_isa_pkg::reg_addr_t wb_rd,
	input  logic                   wb_reg_we,
	input  logic                   id_is_halt,
	input  logic                   redirect,
	output cpu_pipe_pkg::fwd_sel_t fwd_a,
	output cpu_pipe_pkg::fwd_sel_t fwd_b,
	output logic                   stall_front,
	output logic                   flush_if_id,
	output logic                   flush_id_ex
);

	logic load_use;
	logic halt_req;
	logic fetch_stop;

	// Youngest producer wins, r0 never forwarded
	function automatic cpu_pipe_pkg::fwd_sel_t fwd_pick(
		input cpu_isa_pkg::reg_addr_t src,
		input cpu_isa_pkg::reg_addr_t m_rd,
		input logic                   m_we,
		input cpu_isa_pkg::reg_addr_t w_rd,
		input logic                   w_we
	);
		if (src == '0) return cpu_pipe_pkg::FWD_NONE;
		if (m_we && m_rd == src) return cpu_pipe_pkg::FWD_EXMEM;
		if (w_we && w_rd == src) return cpu_pipe_pkg::FWD_MEMWB;
		return cpu_pipe_pkg::FWD_NONE;
	endfunction

	assign fwd_a = fwd_pick(ex_rs, mem_rd, mem_reg_we, wb_rd, wb_reg_we);
	assign fwd_b = fwd_pick(ex_rt, mem_rd, mem_reg_we, wb_rd, wb_reg_we);

	// LW in EX feeding ID
	assign load_use = ex_is_load && ex_rd != '0 &&
		(id_rs == ex_rd || (id_reads_rt && id_rt == ex_rd));

	// HLT on a flushed path is ignored
	assign halt_req = id_is_halt && !redirect;

	always_ff @(posedge clk) begin
		if (rst) begin
			fetch_stop <= 1'b0;
		end else if (halt_req) begin
			fetch_stop <= 1'b1;
		end
	end

	// Redirect wins through flush and PC priority
	assign stall_front = load_use || halt_req || fetch_stop;
	assign flush_if_id = redirect || halt_req || fetch_stop;
	assign flush_id_ex = redirect || load_use;

endmodule

/* src/cpu.sv */
`timescale 1ns/1ps

module cpu (
	input  logic               clk,
	input  logic               rst,
	output cpu_isa_pkg::word_t i_addr,
	input  cpu_isa_pkg::word_t instr,
	output cpu_isa_pkg::word_t d_addr,
	output cpu_isa_pkg::word_t d_wdata,
	output logic               d_we,
	output logic               d_re,
	input  cpu_isa_pkg::word_t d_rdata,
	output logic               hlt
);

	cpu_isa_pkg::word_t pc;
	cpu_isa_pkg::word_t pc_plus1;
	cpu_isa_pkg::word_t redirect_pc;
	cpu_isa_pkg::word_t wb_data;
	logic redirect;
	logic stall_front;
	logic flush_if_id;
	logic flush_id_ex;
	logic id_reads_rt;
	logic id_is_halt;
	cpu_pipe_pkg::fwd_sel_t fwd_a;
	cpu_pipe_pkg::fwd_sel_t fwd_b;
	cpu_pipe_pkg::if_id_t if_id_d;
	cpu_pipe_pkg::if_id_t if_id_q;
	cpu_pipe_pkg::id_ex_t id_ex_d;
	cpu_pipe_pkg::id_ex_t id_ex_q;
	cpu_pipe_pkg::ex_mem_t ex_mem_d;
	cpu_pipe_pkg::ex_mem_t ex_mem_q;
	cpu_pipe_pkg::mem_wb_t mem_wb_d;
	cpu_pipe_pkg::mem_wb_t mem_wb_q;

	////////////////////////////////////////
	// Fetch
	assign pc_plus1 = pc + 1'b1;
	assign i_addr = pc;

	// Redirect beats stall
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= redirect_pc;
		end else if (!stall_front) begin
			pc <= pc_plus1;
		end
	end

	assign if_id_d = '{valid: 1'b1, pc_next: pc_plus1, instr: instr};

	pipe_reg #(.PAYLOAD_T(cpu_pipe_pkg::if_id_t)) u_if_id (
		.clk(clk), .rst(rst), .stall(stall_front), .flush(flush_if_id),
		.d(if_id_d), .q(if_id_q)
	);

	////////////////////////////////////////
	// Decode
	instr_decode u_decode (
		.clk(clk),
		.rst(rst),
		.if_id(if_id_q),
		.wb_we(mem_wb_q.reg_we),
		.wb_rd(mem_wb_q.rd),
		.wb_data(wb_data),
		.id_ex(id_ex_d)
	);

	// Hazard inputs from ID
	assign id_reads_rt = if_id_q.valid &&
		cpu_isa_pkg::reads_rt(cpu_isa_pkg::opcode_t'(if_id_q.instr[15:12]));
	assign id_is_halt = id_ex_d.valid && id_ex_d.ctrl.is_halt;

	pipe_reg #(.PAYLOAD_T(cpu_pipe_pkg::id_ex_t)) u_id_ex (
		.clk(clk), .rst(rst), .stall(1'b0), .flush(flush_id_ex),
		.d(id_ex_d), .q(id_ex_q)
	);

	////////////////////////////////////////
	// Execute
	execute u_execute (
		.clk(clk),
		.rst(rst),
		.id_ex(id_ex_q),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.ex_mem_fwd(ex_mem_q.result),
		.mem_wb_fwd(wb_data),
		.ex_mem(ex_mem_d),
		.redirect(redirect),
		.redirect_pc(redirect_pc)
	);

	pipe_reg #(.PAYLOAD_T(cpu_pipe_pkg::ex_mem_t)) u_ex_mem (
		.clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0),
		.d(ex_mem_d), .q(ex_mem_q)
	);

	// Memory stage, data memory answers in the same cycle
	assign d_addr = ex_mem_q.result;
	assign d_wdata = ex_mem_q.store_data;
	assign d_we = ex_mem_q.mem_we;
	assign d_re = ex_mem_q.mem_re;

	assign mem_wb_d = '{valid: ex_mem_q.valid, result: ex_mem_q.result, load_data: d_rdata,
		rd: ex_mem_q.rd, reg_we: ex_mem_q.reg_we, mem_to_reg: ex_mem_q.mem_to_reg,
		is_halt: ex_mem_q.is_halt};

	pipe_reg #(.PAYLOAD_T(cpu_pipe_pkg::mem_wb_t)) u_mem_wb (
		.clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0),
		.d(mem_wb_d), .q(mem_wb_q)
	);

	////////////////////////////////////////
	// Writeback select, also the MEM/WB forward value
	assign wb_data = mem_wb_q.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.result;

	// Sticky halt
	always_ff @(posedge clk) begin
		if (rst) begin
			hlt <= 1'b0;
		end else if (mem_wb_q.valid && mem_wb_q.is_halt) begin
			hlt <= 1'b1;
		end
	end

	hazard_unit u_hazard (
		.clk(clk),
		.rst(rst),
		.id_rs(id_ex_d.rs),
		.id_rt(id_ex_d.rt),
		.id_reads_rt(id_reads_rt),
		.ex_rd(id_ex_q.rd),
		.ex_is_load(id_ex_q.valid && id_ex_q.ctrl.mem_re),
		.ex_rs(id_ex_q.rs),
		.ex_rt(id_ex_q.rt),
		.mem_rd(ex_mem_q.rd),
		.mem_reg_we(ex_mem_q.reg_we),
		.wb_rd(mem_wb_q.rd),
		.wb_reg_we(mem_wb_q.reg_we),
		.id_is_halt(id_is_halt),
		.redirect(redirect),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.stall_front(stall_front),
		.flush_if_id(flush_if_id),
		.flush_id_ex(flush_id_ex)
	);

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

// Free-running testbench clock, starts low
module tb_clock #(
	parameter real PERIOD_NS = 8.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk;
	end

endmodule

/* test/cpu_props.sv */
`timescale 1ns/1ps

module cpu_props (
	input logic clk,
	input logic rst,
	input logic redirect,
	input logic load_use,
	input logic fetch_stop,
	input logic stall_front
);

	// Both flushes leave EX empty for the next two cycles
	redirect_flushes: assert property (@(posedge clk) disable iff (rst)
		redirect |=> (!redirect && !load_use) ##1 (!redirect && !load_use))
		else $error("redirect did not clear the two younger stages");

	// Load-use bubble lasts one cycle only
	load_use_once: assert property (@(posedge clk) disable iff (rst)
		load_use |=> !load_use)
		else $error("load-use stall held for two cycles");

	// Fetch stop stays set and nothing younger than HLT reaches EX
	fetch_stop_holds: assert property (@(posedge clk) disable iff (rst)
		fetch_stop |-> (stall_front && !redirect && !load_use) ##1 fetch_stop)
		else $error("fetch stop released or an instruction moved past HLT");

endmodule

bind hazard_unit cpu_props u_props (
	.clk(clk),
	.rst(rst),
	.redirect(redirect),
	.load_use(load_use),
	.fetch_stop(fetch_stop),
	.stall_front(stall_front)
);

/* test/cpu_checker.sv */
`timescale 1ns/1ps

module cpu_checker (
	input  logic             clk,
	input  logic             rst,
	input  logic             test_done,
	input  int               test_idx,
	input  logic [0:3][31:0] exp_stores,
	input  logic [2:0]       exp_count,
	input  logic             d_we,
	input  logic [15:0]      d_addr,
	input  logic [15:0]      d_wdata,
	input  logic [15:0]      i_addr,
	input  logic             hlt,
	output int               n_pass,
	output int               n_fail
);

	logic rst_q = 1'b1;
	logic done_q = 1'b0;
	logic hlt_seen = 1'b0;
	logic [15:0] halt_addr = '0;
	int n_stores = 0;
	int errs = 0;
	int passes = 0;
	int fails = 0;

	assign n_pass = passes;
	assign n_fail = fails;

	// Testbench controls registered one edge later
	always @(posedge clk) begin
		rst_q <= rst;
		done_q <= test_done;
	end

	////////////////////////////////////////
	// DUT outputs settled by the falling edge
	always @(negedge clk) begin
		if (rst_q) begin
			n_stores = 0;
			errs = 0;
			hlt_seen = 1'b0;
		end else begin
			// Stores in program order against the table
			if (d_we) begin
				if (n_stores >= exp_count) begin
					$display("case %0d: extra store of %h to address %h",
						test_idx, d_wdata, d_addr);
					errs++;
				end else if ({d_addr, d_wdata} != exp_stores[n_stores]) begin
					$display("[FAIL] %0t: case %0d store %0d wrote %h to %h, expected %h to %h",
						$time, test_idx, n_stores, d_wdata, d_addr,
						exp_stores[n_stores][15:0], exp_stores[n_stores][31:16]);
					errs++;
				end
				n_stores++;
			end
			// Halt stays high and the fetch address stays frozen
			if (hlt_seen && !hlt) begin
				$display("case %0d: hlt fell before reset", test_idx);
				errs++;
			end
			if (hlt_seen && i_addr != halt_addr) begin
				$display("case %0d: i_addr moved from %h to %h after halt",
					test_idx, halt_addr, i_addr);
				errs++;
			end
			if (hlt && !hlt_seen) begin
				hlt_seen = 1'b1;
				halt_addr = i_addr;
			end
			// End of case summary
			if (done_q) begin
				if (n_stores != exp_count) begin
					$display("case %0d: %0d stores seen, %0d expected",
						test_idx, n_stores, exp_count);
					errs++;
				end
				if (errs == 0) begin
					passes++;
					$display("case %0d: pass, %0d stores", test_idx, n_stores);
				end else begin
					fails++;
					$display("case %0d: fail, %0d errors", test_idx, errs);
				end
			end
		end
	end

endmodule

/* test/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

	localparam int NUM_TESTS = 5;
	localparam int RESET_CYCLES = 16;
	localparam int RUN_CYCLES = 80;
	// Window after hlt for stray stores
	localparam int SETTLE_CYCLES = 8;
	localparam int CYCLE_LIMIT = NUM_TESTS * (RESET_CYCLES + RUN_CYCLES);

	// Program with its expected {addr, data} stores in order and their count
	typedef struct packed {
		logic [0:15][15:0] prog;
		logic [0:3][31:0] stores;
		logic [2:0] n_stores;
	} test_t;

	test_t tests [NUM_TESTS];
	test_t cur;
	logic clk;
	logic rst;
	logic test_done;
	int test_idx;
	int n_pass;
	int n_fail;
	int cycles = 0;
	logic [15:0] i_addr;
	logic [15:0] instr;
	logic [15:0] d_addr;
	logic [15:0] d_wdata;
	logic [15:0] d_rdata;
	logic d_we;
	logic d_re;
	logic hlt;
	logic [15:0] imem [0:15];
	logic [15:0] dmem [0:63];

	tb_clock #(.PERIOD_NS(8.0)) u_clock (.clk(clk));

	cpu u_cpu (
		.clk(clk),
		.rst(rst),
		.i_addr(i_addr),
		.instr(instr),
		.d_addr(d_addr),
		.d_wdata(d_wdata),
		.d_we(d_we),
		.d_re(d_re),
		.d_rdata(d_rdata),
		.hlt(hlt)
	);

	cpu_checker u_checker (
		.clk(clk), .rst(rst), .test_done(test_done), .test_idx(test_idx),
		.exp_stores(cur.stores), .exp_count(cur.n_stores),
		.d_we(d_we), .d_addr(d_addr), .d_wdata(d_wdata), .i_addr(i_addr), .hlt(hlt),
		.n_pass(n_pass), .n_fail(n_fail)
	);

	////////////////////////////////////////
	// Combinational memory models
	// Past the program reads as HLT
	assign instr = (i_addr < 16'd16) ? imem[i_addr[3:0]] : 16'hF000;
	// Read data only under d_re
	assign d_rdata = d_re ? dmem[d_addr[5:0]] : 16'hDEAD;

	always @(posedge clk) begin
		if (d_we) begin
			dmem[d_addr[5:0]] <= d_wdata;
		end
	end

	////////////////////////////////////////
	// Test table
	task automatic fill_table();
		// ALU chain gives r1=1235 r2=FFF0 r3=1225 r4=FFF0 r5=1220 r6=000F r7=00F0 r8=003C
		tests[0].prog = {
			16'hA135, 16'hB112, 16'hA2F0, 16'h0312, 16'h1431, 16'h2543, 16'h3652, 16'h4764,
			16'h5872, 16'hA920, 16'h9490, 16'h9591, 16'h9692, 16'h9893, 16'hF000, 16'h0000
		};
		tests[0].stores = {16'h0020, 16'hFFF0, 16'h0021, 16'h1220,
			16'h0022, 16'h000F, 16'h0023, 16'h003C};
		tests[0].n_stores = 3'd4;
		// Two load-use stalls around stores of 7B and 7B plus base 10
		tests[1].prog = {
			16'hA110, 16'hA27B, 16'h9210, 16'h8310, 16'h0431, 16'h9411, 16'h8511, 16'h9512,
			16'hF000, 16'h9213, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000
		};
		tests[1].stores = {16'h0010, 16'h007B, 16'h0011, 16'h008B,
			16'h0012, 16'h008B, 32'h0};
		tests[1].n_stores = 3'd3;
		// Taken EQ LT GT and not taken NE GE branches
		// GT lands on HLT
		tests[2].prog = {
			16'hA120, 16'hA205, 16'h1322, 16'hC201, 16'h9110, 16'hC001, 16'h9210, 16'h1402,
			16'hC601, 16'h9111, 16'hC801, 16'h9411, 16'h0522, 16'hC401, 16'h9512, 16'hF000
		};
		tests[2].stores = {16'h0020, 16'h0005, 16'h0021, 16'hFFFB, 32'h0, 32'h0};
		tests[2].n_stores = 3'd2;
		// JAL at 1 jumps to 6 and stores link 2
		// JR r15 returns to the 5A marker
		tests[3].prog = {
			16'hA120, 16'hD004, 16'hA25A, 16'h9210, 16'hF000, 16'h9113, 16'h9F11, 16'hE0F0,
			16'h9112, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000
		};
		tests[3].stores = {16'h0021, 16'h0002, 16'h0020, 16'h005A, 32'h0, 32'h0};
		tests[3].n_stores = 3'd2;
		// SW behind HLT stays dead
		tests[4].prog = {
			16'hA120, 16'hA277, 16'h9210, 16'hF000, 16'h9211, 16'h9212, 16'h0000, 16'h0000,
			16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000
		};
		tests[4].stores = {16'h0020, 16'h0077, 32'h0, 32'h0, 32'h0};
		tests[4].n_stores = 3'd1;
	endtask

	task automatic load_test(input int t);
		for (int i = 0; i < 16; i++) begin
			imem[i] = tests[t].prog[i];
		end
		for (int i = 0; i < 64; i++) begin
			dmem[i] = '0;
		end
	endtask

	////////////////////////////////////////
	// Sequencer drives inputs on the falling edge
	initial begin
		rst = 1'b1;
		test_done = 1'b0;
		test_idx = 0;
		cur = '0;
		fill_table();
		for (int t = 0; t < NUM_TESTS; t++) begin
			rst = 1'b1;
			test_idx = t;
			cur = tests[t];
			load_test(t);
			repeat (RESET_CYCLES) @(negedge clk);
			rst = 1'b0;
			while (!hlt) begin
				@(negedge clk);
			end
			repeat (SETTLE_CYCLES) @(negedge clk);
			test_done = 1'b1;
			@(negedge clk);
			test_done = 1'b0;
			@(negedge clk);
		end
		$display("cases passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// Watchdog over the whole run
	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
		$display("Test FAILED");
		$finish;
	end

endmodule

/* src.f */
src/cpu_isa_pkg.sv
src/cpu_pipe_pkg.sv
src/pipe_reg.sv
src/instr_decode.sv
src/execute.sv
src/hazard_unit.sv
src/cpu.sv
test/tb_clock.sv
test/cpu_props.sv
test/cpu_checker.sv
test/cpu_tb.sv
